// ==== rtl/rx_ctrl_defines.svh ====
`ifndef RX_CTRL_DEFINES_SVH
`define RX_CTRL_DEFINES_SVH

// Settings bus register map
`define RX_SR_COMMAND 8'd0  // Flags and line count
`define RX_SR_TIME_HI 8'd1  // Execute time, upper word
`define RX_SR_TIME_LO 8'd2  // Execute time, lower word, queues the command
`define RX_SR_HALT    8'd3
`define RX_SR_MAXLEN  8'd4  // Samples per data packet

// Width of the packet length register
`define RX_MAXLEN_W 16

// Command queue sizing
`define RX_CMD_DEPTH 16
`define RX_CMD_AW    4      // log2 of the depth

`endif

// ==== rtl/rx_ctrl_pkg.sv ====
package rx_ctrl_pkg;

  // One queued capture command, same bit order as the settings words
  typedef struct packed {
    logic        send_imm;  // Start without waiting for rcvtime
    logic        chain;     // Take the next queued command on completion
    logic        reload;    // Repeat when the chain finds nothing queued
    logic        stop;      // Pop and stay idle
    logic [27:0] numlines;  // Samples in this command
    logic [63:0] rcvtime;   // Radio time to start at
  } rx_cmd_t;

  // Error codes, sent in the upper word of the response beat
  typedef enum logic [31:0] {
    ERR_LATECMD     = 32'd2,
    ERR_BROKENCHAIN = 32'd4,
    ERR_OVERRUN     = 32'd8
  } rx_err_e;

  // Framer FSM
  typedef enum logic [1:0] {
    IDLE        = 2'd0,
    RUNNING     = 2'd1,
    ERR_RUNNING = 2'd2,  // Closing the open data packet after an error
    ERR_WAIT    = 2'd3   // Waiting for the error packet to go out
  } rx_state_e;

endpackage

// ==== rtl/rx_cmd_if.sv ====
`timescale 1ns/100ps

// Command queue head, FIFO to framer
interface rx_cmd_if
  import rx_ctrl_pkg::*;
();

  rx_cmd_t cmd;    // Entry at the head of the queue
  logic    valid;
  logic    ready;  // Pops together with valid, may follow cmd combinationally
  logic    flush;  // Empties the queue on the next edge

  modport fifo (output cmd, output valid, input ready, input flush);

  modport framer (input cmd, input valid, output ready, output flush);

endinterface

// ==== rtl/rx_settings.sv ====
`timescale 1ns/100ps
`include "rx_ctrl_defines.svh"

module rx_settings
  import rx_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        clear,
  input  logic        set_stb,
  input  logic [7:0]  set_addr,
  input  logic [31:0] set_data,
  output logic        push,
  output rx_cmd_t     push_cmd,
  output logic        halt_req,
  output logic [15:0] maxlen
);

  logic [31:0] cmd_word;
  logic [31:0] time_hi;
  logic [31:0] time_lo;
  logic        wr_cmd;
  logic        wr_time_hi;
  logic        wr_time_lo;
  logic        wr_halt;
  logic        wr_maxlen;

  // Address decode
  assign wr_cmd     = set_stb && (set_addr == `RX_SR_COMMAND);
  assign wr_time_hi = set_stb && (set_addr == `RX_SR_TIME_HI);
  assign wr_time_lo = set_stb && (set_addr == `RX_SR_TIME_LO);
  assign wr_halt    = set_stb && (set_addr == `RX_SR_HALT);
  assign wr_maxlen  = set_stb && (set_addr == `RX_SR_MAXLEN);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cmd_word <= '0;
      time_hi  <= '0;
      time_lo  <= '0;
      maxlen   <= '0;
    end else begin
      if (wr_cmd)     cmd_word <= set_data;
      if (wr_time_hi) time_hi  <= set_data;
      if (wr_time_lo) time_lo  <= set_data;
      if (wr_maxlen)  maxlen   <= set_data[`RX_MAXLEN_W-1:0];
    end
  end

  // Time-low write queues the command one cycle after the registers take it
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      push     <= 1'b0;
      halt_req <= 1'b0;
    end else if (clear) begin
      push     <= 1'b0;
      halt_req <= 1'b0;
    end else begin
      push     <= wr_time_lo;
      halt_req <= wr_halt;  // Single cycle pulse
    end
  end

  assign push_cmd = {cmd_word, time_hi, time_lo};

endmodule

// ==== rtl/rx_cmd_fifo.sv ====
`timescale 1ns/100ps
`include "rx_ctrl_defines.svh"

module rx_cmd_fifo
  import rx_ctrl_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  logic    clear,
  input  logic    push,
  input  rx_cmd_t push_cmd,
  rx_cmd_if.fifo  cmd
);

  rx_cmd_t             mem [`RX_CMD_DEPTH];
  logic [`RX_CMD_AW-1:0] wr_ptr;
  logic [`RX_CMD_AW-1:0] rd_ptr;
  logic [`RX_CMD_AW:0]   count;
  logic                full;
  logic                do_push;
  logic                do_pop;

  assign full    = count[`RX_CMD_AW];  // Depth is a power of two
  assign do_push = push & ~full;       // Commands written into a full queue are lost
  assign do_pop  = cmd.valid & cmd.ready;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_cmd;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (clear || cmd.flush) begin
      wr_ptr <= '0;  // A push in this cycle goes nowhere
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign cmd.valid = (count != '0);
  assign cmd.cmd   = mem[rd_ptr];

  // Pointers must agree the queue holds an entry on every pop
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!arst_n)
    do_pop |-> (wr_ptr != rd_ptr) || full
  ) else $error("rx_cmd_fifo: pop while empty");

endmodule

// ==== rtl/rx_framer.sv ====
`timescale 1ns/100ps

module rx_framer
  import rx_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  input  logic         clear,
  rx_cmd_if.framer     cmd,
  input  logic         halt_req,
  input  logic [15:0]  maxlen,
  input  logic [63:0]  vita_time,
  input  logic [31:0]  sid,
  input  logic [31:0]  forwarding_sid,
  input  logic [31:0]  sample,
  input  logic         strobe,
  output logic         run,
  output logic [31:0]  rx_tdata,
  output logic         rx_tlast,
  output logic         rx_tvalid,
  input  logic         rx_tready,
  output logic [127:0] rx_tuser,
  output logic [63:0]  resp_tdata,
  output logic [127:0] resp_tuser,
  output logic         resp_tlast,
  output logic         resp_tvalid,
  input  logic         resp_tready
);

  rx_state_e    state;
  logic [27:0]  lines_left;      // Left in the current command
  logic [27:0]  repeat_lines;    // Reload value of the current command
  logic [15:0]  lines_left_pkt;  // Left in the open packet
  logic         chain_sav;
  logic         reload_sav;
  logic         halt;
  logic         now;
  logic         late;
  logic         last_line;
  logic         first_beat;
  logic         eob;
  logic [63:0]  start_time;
  logic [63:0]  beat_time;
  logic [127:0] err_header;

  // Time compare against the head of the queue
  assign now  = (vita_time == cmd.cmd.rcvtime);
  assign late = (vita_time > cmd.cmd.rcvtime);

  assign err_header = {2'b11, 1'b1, 1'b1, 12'd0, 16'd0, forwarding_sid, vita_time};

  assign run        = (state == RUNNING);
  assign last_line  = strobe & (lines_left == 28'd1);
  assign first_beat = run & (lines_left_pkt == maxlen);

  always_comb begin
    case (state)
      IDLE:    cmd.ready = cmd.valid & ~cmd.flush & ~halt &
                           (cmd.cmd.stop | cmd.cmd.send_imm | late | now);
      RUNNING: cmd.ready = cmd.valid & last_line & rx_tready & chain_sav & ~halt;
      default: cmd.ready = 1'b0;
    endcase
  end

  // End of burst when this command does not hand over to another one
  assign eob = (run & last_line &
               (~chain_sav | halt | (cmd.valid & cmd.cmd.stop) | (~cmd.valid & ~reload_sav)))
               | (state == ERR_RUNNING);

  assign beat_time = first_beat ? vita_time : start_time;

  assign rx_tdata  = sample;
  assign rx_tvalid = (run & strobe) | (state == ERR_RUNNING);
  assign rx_tlast  = eob | (lines_left_pkt == 16'd1) | (state == ERR_RUNNING);
  assign rx_tuser  = {3'b001, eob, 12'h0, 16'h0, sid, beat_time};  // No seqnum or length

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state          <= IDLE;
      lines_left     <= '0;
      repeat_lines   <= '0;
      lines_left_pkt <= '0;
      chain_sav      <= 1'b0;
      reload_sav     <= 1'b0;
      halt           <= 1'b0;
      cmd.flush      <= 1'b0;
      start_time     <= '0;
      resp_tdata     <= '0;
      resp_tuser     <= '0;
      resp_tlast     <= 1'b0;
      resp_tvalid    <= 1'b0;
    end else if (clear) begin
      state       <= IDLE;
      chain_sav   <= 1'b0;
      reload_sav  <= 1'b0;
      halt        <= 1'b0;
      cmd.flush   <= 1'b0;
      resp_tlast  <= 1'b0;
      resp_tvalid <= 1'b0;
    end else begin
      cmd.flush <= 1'b0;
      case (state)
        IDLE: begin
          if (halt) begin
            halt      <= 1'b0;  // Nothing running, drop the queue right away
            cmd.flush <= 1'b1;
          end else if (cmd.valid && !cmd.flush && !cmd.cmd.stop) begin
            if (late && !cmd.cmd.send_imm) begin
              resp_tvalid <= 1'b1;
              resp_tlast  <= 1'b1;
              resp_tuser  <= err_header;
              resp_tdata  <= {ERR_LATECMD, 32'd0};
              state       <= ERR_WAIT;
            end else if (now || cmd.cmd.send_imm) begin
              state          <= RUNNING;
              lines_left     <= cmd.cmd.numlines;
              repeat_lines   <= cmd.cmd.numlines;
              chain_sav      <= cmd.cmd.chain;
              reload_sav     <= cmd.cmd.reload;
              lines_left_pkt <= maxlen;
            end
          end
        end

        RUNNING: begin
          if (strobe && !rx_tready) begin
            // Sample with nowhere to go
            resp_tvalid <= 1'b1;
            resp_tlast  <= 1'b1;
            resp_tuser  <= err_header;
            resp_tdata  <= {ERR_OVERRUN, 32'd0};
            state       <= ERR_RUNNING;
          end else if (strobe) begin
            lines_left_pkt <= (lines_left_pkt == 16'd1) ? maxlen : lines_left_pkt - 16'd1;
            if (first_beat) start_time <= vita_time;
            if (lines_left == 28'd1) begin
              if (halt) begin
                halt      <= 1'b0;
                cmd.flush <= 1'b1;
                state     <= IDLE;
              end else if (chain_sav) begin
                if (cmd.valid) begin
                  lines_left   <= cmd.cmd.numlines;  // Next command runs back to back
                  repeat_lines <= cmd.cmd.numlines;
                  chain_sav    <= cmd.cmd.chain;
                  reload_sav   <= cmd.cmd.reload;
                  if (cmd.cmd.stop) state <= IDLE;
                end else if (reload_sav) begin
                  lines_left <= repeat_lines;
                end else begin
                  resp_tvalid <= 1'b1;
                  resp_tlast  <= 1'b1;
                  resp_tuser  <= err_header;
                  resp_tdata  <= {ERR_BROKENCHAIN, 32'd0};
                  state       <= ERR_RUNNING;
                end
              end else begin
                state <= IDLE;
              end
            end else begin
              lines_left <= lines_left - 28'd1;
            end
          end
        end

        ERR_RUNNING: begin
          if (resp_tvalid && resp_tready) begin
            resp_tvalid <= 1'b0;
            resp_tlast  <= 1'b0;
          end
          // Closing beat taken, wait for the error packet if still pending
          if (rx_tready) state <= (resp_tvalid && !resp_tready) ? ERR_WAIT : IDLE;
        end

        ERR_WAIT: begin
          if (resp_tready) begin
            resp_tvalid <= 1'b0;
            resp_tlast  <= 1'b0;
            state       <= IDLE;
          end
        end

        default: state <= IDLE;
      endcase
      if (halt_req) halt <= 1'b1;
    end
  end

  a_resp_hold: assert property (
    @(posedge clk) disable iff (!arst_n || clear)
    resp_tvalid && !resp_tready |=> resp_tvalid && $stable(resp_tdata)
  ) else $error("rx_framer: resp_tvalid dropped before resp_tready");

  // Running only ever starts from a command taken off the queue
  a_run_from_pop: assert property (
    @(posedge clk) disable iff (!arst_n)
    $rose(run) |-> $past(cmd.valid && cmd.ready)
  ) else $error("rx_framer: run rose without a popped command");

endmodule

// ==== rtl/rx_ctrl_top.sv ====
`timescale 1ns/100ps

module rx_ctrl_top
  import rx_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  input  logic         clear,
  input  logic [63:0]  vita_time,
  input  logic [31:0]  sid,
  input  logic [31:0]  forwarding_sid,
  input  logic         set_stb,
  input  logic [7:0]   set_addr,
  input  logic [31:0]  set_data,
  output logic [31:0]  rx_tdata,
  output logic         rx_tlast,
  output logic         rx_tvalid,
  input  logic         rx_tready,
  output logic [127:0] rx_tuser,
  output logic [63:0]  resp_tdata,
  output logic [127:0] resp_tuser,
  output logic         resp_tlast,
  output logic         resp_tvalid,
  input  logic         resp_tready,
  output logic         run,
  input  logic [31:0]  sample,
  input  logic         strobe
);

  logic        push;
  rx_cmd_t     push_cmd;
  logic        halt_req;
  logic [15:0] maxlen;

  rx_cmd_if cmd_bus ();  // Queue head between FIFO and framer

  rx_settings settings_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .clear    (clear),
    .set_stb  (set_stb),
    .set_addr (set_addr),
    .set_data (set_data),
    .push     (push),
    .push_cmd (push_cmd),
    .halt_req (halt_req),
    .maxlen   (maxlen)
  );

  rx_cmd_fifo fifo_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .clear    (clear),
    .push     (push),
    .push_cmd (push_cmd),
    .cmd      (cmd_bus.fifo)
  );

  rx_framer framer_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .clear          (clear),
    .cmd            (cmd_bus.framer),
    .halt_req       (halt_req),
    .maxlen         (maxlen),
    .vita_time      (vita_time),
    .sid            (sid),
    .forwarding_sid (forwarding_sid),
    .sample         (sample),
    .strobe         (strobe),
    .run            (run),
    .rx_tdata       (rx_tdata),
    .rx_tlast       (rx_tlast),
    .rx_tvalid      (rx_tvalid),
    .rx_tready      (rx_tready),
    .rx_tuser       (rx_tuser),
    .resp_tdata     (resp_tdata),
    .resp_tuser     (resp_tuser),
    .resp_tlast     (resp_tlast),
    .resp_tvalid    (resp_tvalid),
    .resp_tready    (resp_tready)
  );

endmodule

// ==== bench/rx_ctrl_checks.sv ====
`timescale 1ns/100ps
`include "rx_ctrl_defines.svh"

// Watches the top-level ports and keeps running totals for the testbench
module rx_ctrl_checks
  import rx_ctrl_pkg::*;
(
  input logic         clk,
  input logic         arst_n,
  input logic         set_stb,
  input logic [7:0]   set_addr,
  input logic [31:0]  set_data,
  input logic [31:0]  sid,
  input logic [31:0]  forwarding_sid,
  input logic [31:0]  sample,
  input logic         run,
  input logic [31:0]  rx_tdata,
  input logic         rx_tlast,
  input logic         rx_tvalid,
  input logic         rx_tready,
  input logic [127:0] rx_tuser,
  input logic [63:0]  resp_tdata,
  input logic [127:0] resp_tuser,
  input logic         resp_tlast,
  input logic         resp_tvalid,
  input logic         resp_tready
);

  int          errors = 0;
  int          beats;      // Accepted data beats
  int          eobs;
  int          eob_beat;   // Value of beats at the latest eob
  int          resps;      // Accepted error packets
  logic [31:0] last_code;
  logic [63:0] pkt_time;   // Header time of the latest packet start
  logic [15:0] maxlen_m;   // Mirror of the packet length register
  logic [15:0] pkt_cnt;    // Beats so far in the open packet
  logic        eob;
  logic        beat;
  logic        exp_tlast;

  assign eob       = rx_tuser[124];
  assign beat      = rx_tvalid & rx_tready;
  assign exp_tlast = (pkt_cnt + 16'd1 == maxlen_m) | eob;  // Every maxlen beats or end of burst

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      beats     <= 0;
      eobs      <= 0;
      eob_beat  <= 0;
      resps     <= 0;
      last_code <= '0;
      pkt_time  <= '0;
      maxlen_m  <= '0;
      pkt_cnt   <= '0;
    end else begin
      if (set_stb && set_addr == `RX_SR_MAXLEN) maxlen_m <= set_data[15:0];
      if (beat) begin
        beats   <= beats + 1;
        pkt_cnt <= rx_tlast ? 16'd0 : pkt_cnt + 16'd1;
        if (pkt_cnt == 16'd0) pkt_time <= rx_tuser[63:0];
        if (eob) begin
          eobs     <= eobs + 1;
          eob_beat <= beats + 1;
        end
      end
      if (resp_tvalid && resp_tready) begin
        resps     <= resps + 1;
        last_code <= resp_tdata[63:32];
      end
    end
  end

  a_data_beat: assert property (@(posedge clk) disable iff (!arst_n)
    rx_tvalid |-> rx_tdata == sample && rx_tuser[127:125] == 3'b001 &&
      rx_tuser[95:64] == sid)
    else begin
      $display("FAIL rx_tdata got %h exp %h, rx_tuser type %h sid %h exp %h",
               $sampled(rx_tdata), $sampled(sample), $sampled(rx_tuser[127:125]),
               $sampled(rx_tuser[95:64]), $sampled(sid));
      errors++;
    end

  a_pkt_last: assert property (@(posedge clk) disable iff (!arst_n)
    beat && run |-> rx_tlast == exp_tlast)
    else begin
      $display("FAIL rx_tlast got %h exp %h", $sampled(rx_tlast), $sampled(exp_tlast));
      errors++;
    end

  // Outside RUNNING the only beat is the one closing the packet
  a_close_beat: assert property (@(posedge clk) disable iff (!arst_n)
    rx_tvalid && !run |-> rx_tlast && eob)
    else begin
      $display("FAIL rx_tlast %h eob %h on closing beat", $sampled(rx_tlast), $sampled(eob));
      errors++;
    end

  a_resp_fields: assert property (@(posedge clk) disable iff (!arst_n)
    resp_tvalid |-> resp_tlast && resp_tuser[127:126] == 2'b11 &&
      resp_tuser[95:64] == forwarding_sid && resp_tdata[31:0] == 32'd0 &&
      (resp_tdata[63:32] == ERR_LATECMD || resp_tdata[63:32] == ERR_BROKENCHAIN ||
       resp_tdata[63:32] == ERR_OVERRUN))
    else begin
      $display("FAIL resp_tdata %h resp_tuser %h exp sid %h", $sampled(resp_tdata),
               $sampled(resp_tuser), $sampled(forwarding_sid));
      errors++;
    end

  a_resp_hold: assert property (@(posedge clk) disable iff (!arst_n)
    resp_tvalid && !resp_tready |=> resp_tvalid && $stable(resp_tdata))
    else begin
      $display("FAIL resp_tvalid %h resp_tdata %h changed while stalled",
               $sampled(resp_tvalid), $sampled(resp_tdata));
      errors++;
    end

endmodule

// ==== bench/rx_ctrl_tb.sv ====
`timescale 1ns/100ps
`include "rx_ctrl_defines.svh"

module rx_ctrl_tb
  import rx_ctrl_pkg::*;
();

  logic         clk;
  logic         arst_n;
  logic         clear;
  logic [63:0]  vita_time;
  logic [31:0]  sid;
  logic [31:0]  forwarding_sid;
  logic         set_stb;
  logic [7:0]   set_addr;
  logic [31:0]  set_data;
  logic [31:0]  rx_tdata;
  logic         rx_tlast;
  logic         rx_tvalid;
  logic         rx_tready;
  logic [127:0] rx_tuser;
  logic [63:0]  resp_tdata;
  logic [127:0] resp_tuser;
  logic         resp_tlast;
  logic         resp_tvalid;
  logic         resp_tready;
  logic         run;
  logic [31:0]  sample;
  logic         strobe;
  integer       seed = 17661;
  int           tb_errors = 0;
  int           b0;  // Checker totals at the start of a test
  int           e0;
  int           r0;
  logic [63:0]  t;

  rx_ctrl_top dut_i (.*);

  rx_ctrl_checks chk_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Radio time and frontend samples with strobe on about half the cycles
  always @(posedge clk) begin
    vita_time <= vita_time + 64'd1;
    sample    <= $random(seed);
    strobe    <= ($random(seed) & 1) != 0;
  end

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    set_stb  <= 1'b1;
    set_addr <= addr;
    set_data <= data;
    @(posedge clk);
    set_stb  <= 1'b0;
  endtask

  // Flags from the top are send_imm, chain, reload, stop
  task automatic queue_cmd(input logic [3:0] flags, input logic [27:0] lines,
                           input logic [63:0] when);
    write_reg(`RX_SR_COMMAND, {flags, lines});
    write_reg(`RX_SR_TIME_HI, when[63:32]);
    write_reg(`RX_SR_TIME_LO, when[31:0]);
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got == exp) else begin
      $display("FAIL %0s got %h exp %h", name, got, exp);
      tb_errors++;
    end
  endtask

  task automatic save_totals();
    b0 = chk_i.beats;
    e0 = chk_i.eobs;
    r0 = chk_i.resps;
  endtask

  task automatic check_deltas(input int nbeats, input int neobs, input int nresps);
    check_eq("rx beats", chk_i.beats - b0, nbeats);
    check_eq("rx eob beats", chk_i.eobs - e0, neobs);
    check_eq("resp packets", chk_i.resps - r0, nresps);
    if (neobs > 0) check_eq("eob position", chk_i.eob_beat, chk_i.beats);  // eob on the final beat
  endtask

  // sel 0 waits for data beats, 1 for error packets, 2 for the framer to go quiet
  task automatic wait_for(input int sel, input int target);
    int n;
    bit done;
    n    = 0;
    done = 1'b0;
    while (!done && n < 2000) begin
      @(negedge clk);
      n++;
      case (sel)
        0:       done = chk_i.beats >= target;
        1:       done = chk_i.resps >= target;
        default: done = !(run || rx_tvalid || resp_tvalid);
      endcase
    end
    if (!done) begin
      $display("Timed out in wait %0d, target %0d never reached", sel, target);
      tb_errors++;
    end
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      assert (!(run || rx_tvalid || resp_tvalid)) else begin
        $display("FAIL run %h rx_tvalid %h resp_tvalid %h, all expected 0",
                 run, rx_tvalid, resp_tvalid);
        tb_errors++;
      end
    end
  endtask

  initial begin
    arst_n         = 1'b0;
    clear          = 1'b0;
    vita_time      = '0;
    sid            = 32'h0000_0a11;
    forwarding_sid = 32'h0000_0b22;
    set_stb        = 1'b0;
    set_addr       = '0;
    set_data       = '0;
    rx_tready      = 1'b1;
    resp_tready    = 1'b1;
    sample         = '0;
    strobe         = 1'b0;
    expect_quiet(3);  // Held in reset
    @(posedge clk);
    arst_n <= 1'b1;
    expect_quiet(8);  // Nothing queued yet
    write_reg(`RX_SR_MAXLEN, 32'd4);

    // Immediate single command of 10 lines in packets of 4
    save_totals();
    queue_cmd(4'b1000, 28'd10, 64'd0);
    wait_for(0, b0 + 10);
    wait_for(2, 0);
    check_deltas(10, 1, 0);

    // Timed command
    save_totals();
    t = vita_time + 64'd50;
    queue_cmd(4'b0000, 28'd6, t);
    expect_quiet(int'(t - vita_time) - 2);
    wait_for(0, b0 + 1);
    assert (chk_i.pkt_time >= t) else begin
      $display("FAIL rx_tuser time %h before rcvtime %h", chk_i.pkt_time, t);
      tb_errors++;
    end
    wait_for(0, b0 + 6);
    wait_for(2, 0);
    check_deltas(6, 1, 0);

    // Late command with the error packet held back for a few cycles
    save_totals();
    @(posedge clk);
    resp_tready <= 1'b0;
    queue_cmd(4'b0000, 28'd6, 64'd5);
    repeat (6) @(posedge clk);
    resp_tready <= 1'b1;
    wait_for(1, r0 + 1);
    wait_for(2, 0);
    check_deltas(0, 0, 1);
    check_eq("resp code", chk_i.last_code, ERR_LATECMD);

    // Overrun
    save_totals();
    queue_cmd(4'b1000, 28'd40, 64'd0);
    wait_for(0, b0 + 3);
    @(posedge clk);
    rx_tready <= 1'b0;  // Next strobe has nowhere to go
    wait_for(1, r0 + 1);
    @(posedge clk);
    rx_tready <= 1'b1;
    wait_for(2, 0);
    check_eq("resp code", chk_i.last_code, ERR_OVERRUN);
    check_eq("resp packets", chk_i.resps - r0, 1);
    check_eq("rx eob beats", chk_i.eobs - e0, 1);
    check_eq("eob position", chk_i.eob_beat, chk_i.beats);
    expect_quiet(20);

    // Two chained commands where the first one is timed so both get queued
    save_totals();
    t = vita_time + 64'd60;
    queue_cmd(4'b0100, 28'd5, t);
    queue_cmd(4'b1000, 28'd7, 64'd0);
    wait_for(0, b0 + 12);
    wait_for(2, 0);
    check_deltas(12, 1, 0);

    // Reloading chain runs on until a halt
    save_totals();
    queue_cmd(4'b1110, 28'd3, 64'd0);
    wait_for(0, b0 + 10);
    check_eq("run", run, 1);
    write_reg(`RX_SR_HALT, 32'd0);
    wait_for(2, 0);
    check_eq("rx beats mod 3", (chk_i.beats - b0) % 3, 0);
    check_eq("rx eob beats", chk_i.eobs - e0, 1);

    // Broken chain
    save_totals();
    queue_cmd(4'b1100, 28'd5, 64'd0);
    wait_for(1, r0 + 1);
    wait_for(2, 0);
    check_deltas(6, 2, 1);
    check_eq("resp code", chk_i.last_code, ERR_BROKENCHAIN);

    // Halt flushes a queued timed command
    save_totals();
    t = vita_time + 64'd40;
    queue_cmd(4'b0000, 28'd4, t);
    write_reg(`RX_SR_HALT, 32'd0);
    expect_quiet(60);
    check_deltas(0, 0, 0);

    // Stop command is consumed and the next one still runs
    save_totals();
    queue_cmd(4'b0001, 28'd0, 64'd0);
    expect_quiet(10);
    queue_cmd(4'b1000, 28'd4, 64'd0);
    wait_for(0, b0 + 4);
    wait_for(2, 0);
    check_deltas(4, 1, 0);

    $display("Checker errors %0d, testbench errors %0d", chk_i.errors, tb_errors);
    if (chk_i.errors == 0 && tb_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+rtl
rtl/rx_ctrl_pkg.sv
rtl/rx_cmd_if.sv
rtl/rx_settings.sv
rtl/rx_cmd_fifo.sv
rtl/rx_framer.sv
rtl/rx_ctrl_top.sv
bench/rx_ctrl_checks.sv
bench/rx_ctrl_tb.sv
